/* rtl/uni_axi_pkg.sv */
/* widths, types and fixed AXI attributes shared by the uni to AXI bridge,
   imported by each RTL module that needs them */
`default_nettype none

package uni_axi_pkg;

  localparam int DATA_W = 64;          // uni and AXI data width
  localparam int STRB_W = DATA_W / 8;  // byte lanes
  localparam int LANE_W = 3;           // byte address bits inside a lane

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [7:0]        len_t;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_t;

  // AXI encoding, higher value means worse outcome
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  localparam logic [1:0] BURST_INCR              = 2'b01;
  localparam logic [2:0] AXI_SIZE_8B             = 3'd3;     // full 64-bit beats
  localparam logic [2:0] PROT_DATA_SECURE_UNPRIV = 3'b000;
  localparam logic [3:0] AWCACHE_WB_RWALLOC      = 4'b1111;
  localparam logic [3:0] ARCACHE_NORMAL_NC_NB    = 4'b0010;

endpackage

`default_nettype wire

/* rtl/uni_axi_ctrl.sv */
/* write and read FSMs of the bridge, one request in flight at a time;
   drives every AXI valid/ready, the beat index and the uni ready/response */
`timescale 1ns/1ps
`default_nettype none

module uni_axi_ctrl import uni_axi_pkg::*; (
  input  wire        i_clk,
  input  wire        i_rst_n,
  input  wire        i_valid,
  input  wire        i_wr,
  input  wire len_t  i_len,
  input  wire        i_aw_ready,
  input  wire        i_w_ready,
  input  wire        i_b_valid,
  input  wire resp_t i_b_resp,
  input  wire        i_ar_ready,
  input  wire        i_r_valid,
  input  wire        i_r_last,
  input  wire resp_t i_r_resp,
  output logic       o_aw_valid,
  output logic       o_w_valid,
  output logic       o_w_last,
  output logic       o_b_ready,
  output logic       o_ar_valid,
  output logic       o_r_ready,
  output logic       o_beat,
  output logic       o_r_capture,
  output logic       o_ready,
  output resp_t      o_resp
);

  typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} w_state_t;
  typedef enum logic [1:0] {R_IDLE, R_ADDR, R_READ} r_state_t;

  w_state_t w_state;
  r_state_t r_state;
  len_t     beat_cnt;
  logic     idle;
  logic     start;
  logic     w_hs;
  logic     b_hs;
  logic     r_hs;

  assign idle  = (w_state == W_IDLE) && (r_state == R_IDLE);
  // request is still held during the ready pulse, don't restart on it
  assign start = i_valid && !o_ready && idle;
  assign w_hs  = o_w_valid && i_w_ready;
  assign b_hs  = o_b_ready && i_b_valid;
  assign r_hs  = o_r_ready && i_r_valid;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      w_state <= W_IDLE;
    end else begin
      case (w_state)
        W_IDLE:  if (start && i_wr) w_state <= W_ADDR;
        W_ADDR:  if (i_aw_ready) w_state <= W_DATA;
        W_DATA:  if (w_hs && o_w_last) w_state <= W_RESP;
        W_RESP:  if (b_hs) w_state <= W_IDLE;
        default: w_state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_state <= R_IDLE;
    end else begin
      case (r_state)
        R_IDLE:  if (start && !i_wr) r_state <= R_ADDR;
        R_ADDR:  if (i_ar_ready) r_state <= R_READ;
        R_READ:  if (r_hs && i_r_last) r_state <= R_IDLE;
        default: r_state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || idle) begin
      beat_cnt <= '0;
    end else if (w_hs || r_hs) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  assign o_aw_valid  = (w_state == W_ADDR);
  assign o_w_valid   = (w_state == W_DATA);
  assign o_w_last    = o_w_valid && (beat_cnt == i_len);
  assign o_b_ready   = (w_state == W_RESP);
  assign o_ar_valid  = (r_state == R_ADDR);
  assign o_r_ready   = (r_state == R_READ);
  assign o_beat      = beat_cnt[0];  // at most two beats
  assign o_r_capture = r_hs;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_ready <= 1'b0;
    end else begin
      o_ready <= b_hs || (r_hs && i_r_last);  // one cycle after completion
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_resp <= RESP_OKAY;
    end else if (b_hs) begin
      o_resp <= i_b_resp;
    end else if (r_hs && (!o_beat || i_r_resp > o_resp)) begin
      o_resp <= i_r_resp;  // keep the worst beat
    end
  end

endmodule

`default_nettype wire

/* rtl/uni_beat_plan.sv */
/* combinational burst planning: aligned address, length 0 or 1,
   bit offset and the two per-beat byte masks for one uni request */
`timescale 1ns/1ps
`default_nettype none

module uni_beat_plan import uni_axi_pkg::*; #(
  parameter int ADDR_W = 32
) (
  input  wire [ADDR_W-1:0]  i_addr,
  input  wire size_t        i_size,
  output logic [ADDR_W-1:0] o_axi_addr,
  output len_t              o_len,
  output logic [LANE_W+2:0] o_offset,
  output data_t             o_mask_lo,
  output data_t             o_mask_hi
);

  logic [LANE_W-1:0]   lane;
  logic [LANE_W:0]     last_byte;  // may run into the next lane
  data_t               size_mask;
  logic [2*DATA_W-1:0] wide_mask;

  assign lane      = i_addr[LANE_W-1:0];
  assign last_byte = {1'b0, lane} + ((LANE_W+1)'(1) << i_size) - 1'b1;

  assign o_axi_addr = {i_addr[ADDR_W-1:LANE_W], {LANE_W{1'b0}}};
  assign o_len      = len_t'(last_byte[LANE_W]);  // crossing needs a second beat
  assign o_offset   = {lane, 3'b000};

  always_comb begin
    case (i_size)
      SIZE_B:  size_mask = data_t'(8'hff);
      SIZE_H:  size_mask = data_t'(16'hffff);
      SIZE_W:  size_mask = data_t'(32'hffff_ffff);
      default: size_mask = '1;
    endcase
  end

  // mask over two lanes, low half is beat 0 and high half is beat 1
  assign wide_mask = {{DATA_W{1'b0}}, size_mask} << o_offset;
  assign o_mask_lo = wide_mask[DATA_W-1:0];
  assign o_mask_hi = wide_mask[2*DATA_W-1:DATA_W];

endmodule

`default_nettype wire

/* rtl/uni_wdata_align.sv */
/* moves right-aligned uni write data into lane position and
   selects the data and strobes for the current W beat */
`timescale 1ns/1ps
`default_nettype none

module uni_wdata_align import uni_axi_pkg::*; (
  input  wire data_t        i_wdata,
  input  wire [LANE_W+2:0]  i_offset,
  input  wire data_t        i_mask_lo,
  input  wire data_t        i_mask_hi,
  input  wire               i_beat,
  output data_t             o_w_data,
  output strb_t             o_w_strb
);

  localparam int SH_W = LANE_W + 4;  // wide enough to hold DATA_W

  logic [SH_W-1:0] hi_shift;
  data_t           lo_data;
  data_t           hi_data;
  data_t           sel_mask;

  assign hi_shift = SH_W'(DATA_W) - {1'b0, i_offset};

  assign lo_data = (i_wdata << i_offset) & i_mask_lo;
  // bytes that spill past the lane land at the bottom of beat 1
  assign hi_data = (i_wdata >> hi_shift) & i_mask_hi;

  assign o_w_data = i_beat ? hi_data : lo_data;
  assign sel_mask = i_beat ? i_mask_hi : i_mask_lo;

  always_comb begin
    for (int i = 0; i < STRB_W; i++) begin
      o_w_strb[i] = sel_mask[8*i];  // one mask bit per byte is enough
    end
  end

endmodule

`default_nettype wire

/* rtl/uni_rdata_merge.sv */
/* collects the R beats of one read and builds the right-aligned,
   zero-extended uni read data; updates on each captured beat */
`timescale 1ns/1ps
`default_nettype none

module uni_rdata_merge import uni_axi_pkg::*; #(
  parameter int ADDR_W = 32
) (
  input  wire               i_clk,
  input  wire               i_rst_n,
  input  wire               i_capture,
  input  wire               i_beat,
  input  wire data_t        i_r_data,
  input  wire [LANE_W+2:0]  i_offset,
  input  wire data_t        i_mask_lo,
  input  wire data_t        i_mask_hi,
  output data_t             o_rdata
);

  localparam int SH_W = LANE_W + 4;

  logic [SH_W-1:0] hi_shift;
  data_t           lo_part;
  data_t           hi_part;

  assign hi_shift = SH_W'(DATA_W) - {1'b0, i_offset};

  // masking drops bytes outside the access, so the result is zero-extended
  assign lo_part = (i_r_data & i_mask_lo) >> i_offset;
  assign hi_part = (i_r_data & i_mask_hi) << hi_shift;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_rdata <= '0;
    end else if (i_capture) begin
      if (!i_beat) begin
        o_rdata <= lo_part;  // first beat starts a fresh result
      end else begin
        o_rdata <= o_rdata | hi_part;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/uni2axi_top.sv */
/* uni load/store port to AXI4 master bridge; one burst per request,
   two beats when the access crosses a 64-bit lane */
`timescale 1ns/1ps
`default_nettype none

module uni2axi_top import uni_axi_pkg::*; #(
  parameter int ADDR_W = 32
) (
  input  wire               i_clk,
  input  wire               i_rst_n,
  // uni port
  input  wire               i_valid,
  input  wire               i_wr,
  input  wire [ADDR_W-1:0]  i_addr,
  input  wire size_t        i_size,
  input  wire data_t        i_wdata,
  output logic              o_ready,
  output resp_t             o_resp,
  output data_t             o_rdata,
  // AW
  output logic              o_aw_valid,
  input  wire               i_aw_ready,
  output logic [ADDR_W-1:0] o_aw_addr,
  output len_t              o_aw_len,
  output logic [2:0]        o_aw_size,
  output logic [1:0]        o_aw_burst,
  output logic [2:0]        o_aw_prot,
  output logic [3:0]        o_aw_cache,
  // W
  output logic              o_w_valid,
  input  wire               i_w_ready,
  output data_t             o_w_data,
  output strb_t             o_w_strb,
  output logic              o_w_last,
  // B
  input  wire               i_b_valid,
  output logic              o_b_ready,
  input  wire resp_t        i_b_resp,
  // AR
  output logic              o_ar_valid,
  input  wire               i_ar_ready,
  output logic [ADDR_W-1:0] o_ar_addr,
  output len_t              o_ar_len,
  output logic [2:0]        o_ar_size,
  output logic [1:0]        o_ar_burst,
  output logic [2:0]        o_ar_prot,
  output logic [3:0]        o_ar_cache,
  // R
  input  wire               i_r_valid,
  output logic              o_r_ready,
  input  wire data_t        i_r_data,
  input  wire resp_t        i_r_resp,
  input  wire               i_r_last
);

  logic [ADDR_W-1:0] axi_addr;
  len_t              len;
  logic [LANE_W+2:0] offset;
  data_t             mask_lo;
  data_t             mask_hi;
  logic              beat;
  logic              r_capture;

  uni_axi_ctrl u_ctrl (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (i_valid),
    .i_wr        (i_wr),
    .i_len       (len),
    .i_aw_ready  (i_aw_ready),
    .i_w_ready   (i_w_ready),
    .i_b_valid   (i_b_valid),
    .i_b_resp    (i_b_resp),
    .i_ar_ready  (i_ar_ready),
    .i_r_valid   (i_r_valid),
    .i_r_last    (i_r_last),
    .i_r_resp    (i_r_resp),
    .o_aw_valid  (o_aw_valid),
    .o_w_valid   (o_w_valid),
    .o_w_last    (o_w_last),
    .o_b_ready   (o_b_ready),
    .o_ar_valid  (o_ar_valid),
    .o_r_ready   (o_r_ready),
    .o_beat      (beat),
    .o_r_capture (r_capture),
    .o_ready     (o_ready),
    .o_resp      (o_resp)
  );

  uni_beat_plan #(.ADDR_W(ADDR_W)) u_plan (
    .i_addr     (i_addr),
    .i_size     (i_size),
    .o_axi_addr (axi_addr),
    .o_len      (len),
    .o_offset   (offset),
    .o_mask_lo  (mask_lo),
    .o_mask_hi  (mask_hi)
  );

  uni_wdata_align u_walign (
    .i_wdata   (i_wdata),
    .i_offset  (offset),
    .i_mask_lo (mask_lo),
    .i_mask_hi (mask_hi),
    .i_beat    (beat),
    .o_w_data  (o_w_data),
    .o_w_strb  (o_w_strb)
  );

  uni_rdata_merge #(.ADDR_W(ADDR_W)) u_rmerge (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_capture (r_capture),
    .i_beat    (beat),
    .i_r_data  (i_r_data),
    .i_offset  (offset),
    .i_mask_lo (mask_lo),
    .i_mask_hi (mask_hi),
    .o_rdata   (o_rdata)
  );

  // same burst shape on both address channels
  assign o_aw_addr  = axi_addr;
  assign o_aw_len   = len;
  assign o_aw_size  = AXI_SIZE_8B;
  assign o_aw_burst = BURST_INCR;
  assign o_aw_prot  = PROT_DATA_SECURE_UNPRIV;
  assign o_aw_cache = AWCACHE_WB_RWALLOC;

  assign o_ar_addr  = axi_addr;
  assign o_ar_len   = len;
  assign o_ar_size  = AXI_SIZE_8B;
  assign o_ar_burst = BURST_INCR;
  assign o_ar_prot  = PROT_DATA_SECURE_UNPRIV;
  assign o_ar_cache = ARCACHE_NORMAL_NC_NB;

endmodule

`default_nettype wire

/* tests/axi_mem_model.sv */
/* AXI4 slave memory for the bridge testbench; random 0 to 3 cycle
   ready/valid delays and SLVERR for beats inside the error window */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model import uni_axi_pkg::*; #(
  parameter int ADDR_W    = 32,
  parameter int MEM_BYTES = 2048,
  parameter int ERR_BASE  = 'h400,
  parameter int ERR_SIZE  = 16
) (
  input  wire               i_clk,
  input  wire               i_rst_n,
  input  wire               i_aw_valid,
  output logic              o_aw_ready,
  input  wire [ADDR_W-1:0]  i_aw_addr,
  input  wire len_t         i_aw_len,
  input  wire               i_w_valid,
  output logic              o_w_ready,
  input  wire data_t        i_w_data,
  input  wire strb_t        i_w_strb,
  input  wire               i_w_last,
  output logic              o_b_valid,
  input  wire               i_b_ready,
  output resp_t             o_b_resp,
  input  wire               i_ar_valid,
  output logic              o_ar_ready,
  input  wire [ADDR_W-1:0]  i_ar_addr,
  input  wire len_t         i_ar_len,
  output logic              o_r_valid,
  input  wire               i_r_ready,
  output data_t             o_r_data,
  output resp_t             o_r_resp,
  output logic              o_r_last,
  output len_t              o_last_len,   // length of the latest AW or AR burst
  output int                o_last_errs   // bursts with w_last on the wrong beat
);

  logic [7:0] mem [0:MEM_BYTES-1];
  integer     seed = 32'h5acc_e842;

  function automatic int pick_delay();
    return $random(seed) & 3;
  endfunction

  function automatic int slot(input logic [ADDR_W-1:0] a);
    return int'(a % MEM_BYTES);
  endfunction

  function automatic logic in_err(input logic [ADDR_W-1:0] a);
    return (a >= ERR_BASE) && (a < ERR_BASE + ERR_SIZE);
  endfunction

  function automatic data_t load_word(input logic [ADDR_W-1:0] a);
    data_t d;
    for (int i = 0; i < STRB_W; i++) begin
      d[8*i +: 8] = mem[slot(a + i)];
    end
    return d;
  endfunction

  task automatic write_burst();
    logic [ADDR_W-1:0] a;
    len_t              len;
    resp_t             resp;
    repeat (pick_delay()) @(posedge i_clk);
    #2 o_aw_ready = 1'b1;
    @(posedge i_clk);  // aw_valid is held, so this is the handshake
    a = i_aw_addr;
    len = i_aw_len;
    o_last_len = len;
    resp = RESP_OKAY;
    #2 o_aw_ready = 1'b0;
    for (int b = 0; b <= len; b++) begin
      repeat (pick_delay()) @(posedge i_clk);
      #2 o_w_ready = 1'b1;
      do @(posedge i_clk); while (!i_w_valid);
      if (i_w_last !== (b == len)) o_last_errs++;
      if (in_err(a + 8*b)) begin
        resp = RESP_SLVERR;  // erring beat leaves memory alone
      end else begin
        for (int i = 0; i < STRB_W; i++) begin
          if (i_w_strb[i]) mem[slot(a + 8*b + i)] = i_w_data[8*i +: 8];
        end
      end
      #2 o_w_ready = 1'b0;
    end
    repeat (pick_delay()) @(posedge i_clk);
    #2 o_b_valid = 1'b1;
    o_b_resp = resp;
    do @(posedge i_clk); while (!i_b_ready);
    #2 o_b_valid = 1'b0;
  endtask

  task automatic read_burst();
    logic [ADDR_W-1:0] a;
    len_t              len;
    repeat (pick_delay()) @(posedge i_clk);
    #2 o_ar_ready = 1'b1;
    @(posedge i_clk);
    a = i_ar_addr;
    len = i_ar_len;
    o_last_len = len;
    #2 o_ar_ready = 1'b0;
    for (int b = 0; b <= len; b++) begin
      repeat (pick_delay()) @(posedge i_clk);
      #2 o_r_valid = 1'b1;
      o_r_data = load_word(a + 8*b);
      o_r_resp = in_err(a + 8*b) ? RESP_SLVERR : RESP_OKAY;
      o_r_last = (b == len);
      do @(posedge i_clk); while (!i_r_ready);
      #2 o_r_valid = 1'b0;
      o_r_last = 1'b0;
    end
  endtask

  initial begin
    o_aw_ready  = 1'b0;
    o_w_ready   = 1'b0;
    o_b_valid   = 1'b0;
    o_b_resp    = RESP_OKAY;
    o_ar_ready  = 1'b0;
    o_r_valid   = 1'b0;
    o_r_data    = '0;
    o_r_resp    = RESP_OKAY;
    o_r_last    = 1'b0;
    o_last_len  = '0;
    o_last_errs = 0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = i[7:0] ^ (i[10:8] * 8'h35);  // fill from all address bits
    end
    forever begin
      @(posedge i_clk);
      if (i_rst_n && i_aw_valid) begin
        write_burst();
      end else if (i_rst_n && i_ar_valid) begin
        read_burst();
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_uni2axi.sv */
/* directed testbench for the uni to AXI bridge; each test task issues
   uni requests against the AXI memory model and checks the responses */
`timescale 1ns/1ps
`default_nettype none

module tb_uni2axi
  import uni_axi_pkg::*;
();

  localparam int ADDR_W     = 32;
  localparam int CLK_PERIOD = 20;
  localparam int MEM_BYTES  = 2048;
  localparam int N_REQ      = 100;  // total uni requests over all tests

  logic              clk;
  logic              rst_n;
  logic              valid;
  logic              wr;
  logic [ADDR_W-1:0] addr;
  size_t             size;
  data_t             wdata;
  logic              ready;
  resp_t             resp;
  data_t             rdata;
  logic              aw_valid, aw_ready, w_valid, w_ready, w_last;
  logic              b_valid, b_ready, ar_valid, ar_ready;
  logic              r_valid, r_ready, r_last;
  logic [ADDR_W-1:0] aw_addr, ar_addr;
  len_t              aw_len, ar_len, last_len;
  logic [2:0]        aw_size, ar_size;
  logic [1:0]        aw_burst, ar_burst;
  logic [2:0]        aw_prot, ar_prot;
  logic [3:0]        aw_cache, ar_cache;
  data_t             w_data, r_data;
  strb_t             w_strb;
  resp_t             b_resp, r_resp;
  int                last_errs;

  logic [7:0] ref_mem [0:MEM_BYTES-1];
  integer     seed = 32'h5acc_e842;
  int         n_pass = 0;
  int         n_fail = 0;

  uni2axi_top #(.ADDR_W(ADDR_W)) dut (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_valid    (valid),
    .i_wr       (wr),
    .i_addr     (addr),
    .i_size     (size),
    .i_wdata    (wdata),
    .o_ready    (ready),
    .o_resp     (resp),
    .o_rdata    (rdata),
    .o_aw_valid (aw_valid),
    .i_aw_ready (aw_ready),
    .o_aw_addr  (aw_addr),
    .o_aw_len   (aw_len),
    .o_aw_size  (aw_size),
    .o_aw_burst (aw_burst),
    .o_aw_prot  (aw_prot),
    .o_aw_cache (aw_cache),
    .o_w_valid  (w_valid),
    .i_w_ready  (w_ready),
    .o_w_data   (w_data),
    .o_w_strb   (w_strb),
    .o_w_last   (w_last),
    .i_b_valid  (b_valid),
    .o_b_ready  (b_ready),
    .i_b_resp   (b_resp),
    .o_ar_valid (ar_valid),
    .i_ar_ready (ar_ready),
    .o_ar_addr  (ar_addr),
    .o_ar_len   (ar_len),
    .o_ar_size  (ar_size),
    .o_ar_burst (ar_burst),
    .o_ar_prot  (ar_prot),
    .o_ar_cache (ar_cache),
    .i_r_valid  (r_valid),
    .o_r_ready  (r_ready),
    .i_r_data   (r_data),
    .i_r_resp   (r_resp),
    .i_r_last   (r_last)
  );

  axi_mem_model #(.ADDR_W(ADDR_W), .MEM_BYTES(MEM_BYTES)) u_slave (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_aw_valid  (aw_valid),
    .o_aw_ready  (aw_ready),
    .i_aw_addr   (aw_addr),
    .i_aw_len    (aw_len),
    .i_w_valid   (w_valid),
    .o_w_ready   (w_ready),
    .i_w_data    (w_data),
    .i_w_strb    (w_strb),
    .i_w_last    (w_last),
    .o_b_valid   (b_valid),
    .i_b_ready   (b_ready),
    .o_b_resp    (b_resp),
    .i_ar_valid  (ar_valid),
    .o_ar_ready  (ar_ready),
    .i_ar_addr   (ar_addr),
    .i_ar_len    (ar_len),
    .o_r_valid   (r_valid),
    .i_r_ready   (r_ready),
    .o_r_data    (r_data),
    .o_r_resp    (r_resp),
    .o_r_last    (r_last),
    .o_last_len  (last_len),
    .o_last_errs (last_errs)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    #(CLK_PERIOD * (N_REQ * 40 + 200));
    $display("watchdog expired, the run hung waiting for the bridge");
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic int slot(input logic [ADDR_W-1:0] a);
    return int'(a % MEM_BYTES);
  endfunction

  // second beat needed when the last byte leaves the 8-byte lane
  function automatic len_t exp_len(input logic [ADDR_W-1:0] a, input size_t s);
    return len_t'((a % 8 + (1 << s) - 1) / 8);
  endfunction

  function automatic data_t ref_load(input logic [ADDR_W-1:0] a, input size_t s);
    data_t d;
    d = '0;
    for (int i = 0; i < (1 << s); i++) begin
      d[8*i +: 8] = ref_mem[slot(a + i)];
    end
    return d;
  endfunction

  function automatic data_t rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic ref_store(input logic [ADDR_W-1:0] a, input size_t s, input data_t d);
    for (int i = 0; i < (1 << s); i++) begin
      ref_mem[slot(a + i)] = d[8*i +: 8];
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected resp %0d, actual %0d", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_len(input string name, input len_t exp, input len_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected len %0d, actual %0d", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_attr(input string name, input logic [3:0] exp,
                            input logic [3:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  // called 2 ns after a rising edge, returns 2 ns after the ready edge
  task automatic access(input logic w, input logic [ADDR_W-1:0] a, input size_t s,
                        input data_t d, output data_t rd, output resp_t rs);
    valid = 1'b1;
    wr    = w;
    addr  = a;
    size  = s;
    wdata = d;
    do @(posedge clk); while (ready !== 1'b1);
    rd = rdata;
    rs = resp;
    #2 valid = 1'b0;
  endtask

  task automatic write_check(input string name, input logic [ADDR_W-1:0] a,
                             input size_t s, input data_t d, input resp_t exp_resp);
    data_t rd;
    resp_t rs;
    access(1'b1, a, s, d, rd, rs);
    check_resp(name, exp_resp, rs);
    check_len(name, exp_len(a, s), last_len);
    if (exp_resp == RESP_OKAY) ref_store(a, s, d);
  endtask

  task automatic read_check(input string name, input logic [ADDR_W-1:0] a,
                            input size_t s, input resp_t exp_resp);
    data_t rd;
    resp_t rs;
    access(1'b0, a, s, '0, rd, rs);
    check_resp(name, exp_resp, rs);
    check_len(name, exp_len(a, s), last_len);
    if (exp_resp == RESP_OKAY) check_data(name, ref_load(a, s), rd);
  endtask

  task automatic report(input string name, input int fails_before);
    if (n_fail == fails_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d failing checks", name, n_fail - fails_before);
    end
  endtask

  task automatic test_reset_state();
    int f0;
    f0 = n_fail;
    if ({ready, aw_valid, w_valid, b_ready, ar_valid, r_ready} !== 6'b0) begin
      $display("after reset o_ready or an AXI valid or ready output is not low");
      n_fail++;
    end else begin
      n_pass++;
    end
    report("reset_state", f0);
  endtask

  task automatic test_attributes();
    int f0;
    f0 = n_fail;
    check_attr("aw_size", 4'd3, aw_size);  // 8 bytes per beat
    check_attr("aw_burst", 4'b0001, aw_burst);  // INCR
    check_attr("aw_prot", 4'b0000, aw_prot);
    check_attr("aw_cache", 4'b1111, aw_cache);  // write-back, read and write allocate
    check_attr("ar_size", 4'd3, ar_size);
    check_attr("ar_burst", 4'b0001, ar_burst);
    check_attr("ar_prot", 4'b0000, ar_prot);
    check_attr("ar_cache", 4'b0010, ar_cache);  // normal non-cacheable non-bufferable
    report("attributes", f0);
  endtask

  task automatic test_aligned_dword();
    int f0;
    f0 = n_fail;
    write_check("aligned_dword_wr", 'h100, SIZE_D, 64'h0123_4567_89ab_cdef, RESP_OKAY);
    read_check("aligned_dword_rd", 'h100, SIZE_D, RESP_OKAY);
    report("aligned_dword", f0);
  endtask

  task automatic test_sizes_offsets();
    int                f0;
    string             name;
    logic [ADDR_W-1:0] a;
    f0 = n_fail;
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off + (1 << s) <= 8; off++) begin
        a = 'h200 + 8*s + off;
        name = $sformatf("size%0d_off%0d", s, off);
        write_check(name, a, size_t'(s), rand_data(), RESP_OKAY);
        read_check(name, a, size_t'(s), RESP_OKAY);
        read_check({name, "_lane"}, {a[ADDR_W-1:3], 3'b000}, SIZE_D, RESP_OKAY);
      end
    end
    report("sizes_offsets", f0);
  endtask

  task automatic cross_one(input string name, input logic [ADDR_W-1:0] a, input size_t s);
    write_check(name, a, s, rand_data(), RESP_OKAY);
    read_check(name, a, s, RESP_OKAY);
    // both touched lanes, to catch stray strobes
    read_check({name, "_lo"}, {a[ADDR_W-1:3], 3'b000}, SIZE_D, RESP_OKAY);
    read_check({name, "_hi"}, {a[ADDR_W-1:3], 3'b000} + 8, SIZE_D, RESP_OKAY);
  endtask

  task automatic test_lane_cross();
    int f0;
    f0 = n_fail;
    cross_one("word_off6", 'h306, SIZE_W);
    cross_one("dword_off3", 'h313, SIZE_D);
    cross_one("half_off7", 'h327, SIZE_H);
    report("lane_cross", f0);
  endtask

  task automatic test_back_to_back();
    int                f0;
    size_t             s;
    logic [ADDR_W-1:0] a;
    f0 = n_fail;
    for (int i = 0; i < 24; i++) begin
      s = size_t'($random(seed) & 3);
      a = 'h500 + ($random(seed) & 'hff);
      if ($random(seed) & 1) begin
        write_check($sformatf("b2b_wr%0d", i), a, s, rand_data(), RESP_OKAY);
      end else begin
        read_check($sformatf("b2b_rd%0d", i), a, s, RESP_OKAY);
      end
    end
    report("back_to_back", f0);
  endtask

  task automatic test_error_resp();
    int f0;
    f0 = n_fail;
    write_check("err_write", 'h408, SIZE_D, rand_data(), RESP_SLVERR);
    read_check("err_read_split", 'h3fe, SIZE_W, RESP_SLVERR);  // only beat 1 errs
    report("error_resp", f0);
  endtask

  initial begin
    rst_n = 1'b0;
    valid = 1'b0;
    wr    = 1'b0;
    addr  = '0;
    size  = SIZE_B;
    wdata = '0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ref_mem[i] = i[7:0] ^ (i[10:8] * 8'h35);  // same contents as the slave
    end
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
    @(posedge clk);
    #2;
    test_reset_state();
    test_attributes();
    test_aligned_dword();
    test_sizes_offsets();
    test_lane_cross();
    test_back_to_back();
    test_error_resp();
    if (last_errs != 0) begin
      $display("w_last was set on the wrong beat in %0d bursts", last_errs);
      n_fail++;
    end
    $display("summary: %0d passing and %0d failing checks", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
rtl/uni_axi_pkg.sv
rtl/uni_axi_ctrl.sv
rtl/uni_beat_plan.sv
rtl/uni_wdata_align.sv
rtl/uni_rdata_merge.sv
rtl/uni2axi_top.sv
tests/axi_mem_model.sv
tests/tb_uni2axi.sv
